/* include/wordGame_config.svh */
// Word game configuration.
// Sets character width, word length and the mistake limit.
`ifndef WORDGAME_CONFIG_SVH
`define WORDGAME_CONFIG_SVH

// bits per character, wide enough for ASCII.
`define LETTER_W 8

// letters in the secret word.
`define WORD_LEN 5

// wrong guesses that end the game as lost.
`define MAX_MISTAKES 6

`endif

/* source/wordGamePkg.sv */
// Word game shared types.
// Holds the game state encoding and the structs passed between the blocks.
`include "wordGame_config.svh"

package wordGamePkg;

    // width of the position index and of the mistake counter.
    localparam int POS_W = (`WORD_LEN > 1) ? $clog2(`WORD_LEN) : 1;
    localparam int MIS_W = $clog2(`MAX_MISTAKES + 1);

    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        SCAN  = 3'd1,
        JUDGE = 3'd2,
        WON   = 3'd3,
        LOST  = 3'd4
    } gameState_t;

    // control to scanner.
    typedef struct packed {
        logic                 clear;
        logic                 step;
        logic [POS_W-1:0]     position;
        logic [`LETTER_W-1:0] guess;
    } scanCmd_t;

    // scanner back to control.
    typedef struct packed {
        logic [`WORD_LEN-1:0] revealed;
        logic                 turnHit;
    } scanResult_t;

    typedef struct packed {
        logic             ready;
        logic             turnDone;  // single cycle, when a turn is judged.
        logic             hit;
        logic [MIS_W-1:0] mistakes;
        logic             won;
        logic             lost;
    } gameStatus_t;

endpackage

/* source/wordLoader.sv */
// Secret word loader.
// Shift register that collects the host's letters while no game runs.
`timescale 1ns/1ps
`include "wordGame_config.svh"

module wordLoader (
    input  logic                                clk,
    input  logic                                nRst,
    input  logic                                loadStrobe,
    input  logic [`LETTER_W-1:0]                loadLetter,
    input  logic                                loadEnable,
    output logic [`WORD_LEN-1:0][`LETTER_W-1:0] word
);

    logic shiftIn;

    // loads are only taken between games, the word is frozen while playing.
    assign shiftIn = loadStrobe && loadEnable;

    // ============================================================
    // letter shift register
    // ============================================================
    // New letters enter at the top position and move down on each load.
    // After WORD_LEN loads the first letter sits at position 0, so the
    // word reads in the order it was typed.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            word <= '0;
        end else if (shiftIn) begin
            word <= {loadLetter, word[`WORD_LEN-1:1]};
        end
    end

endmodule

/* source/letterScanner.sv */
// Letter scanner.
// Compares the held guess with one word position per step and builds the revealed mask.
`timescale 1ns/1ps
`include "wordGame_config.svh"

module letterScanner (
    input  logic                                clk,
    input  logic                                nRst,
    input  logic [`WORD_LEN-1:0][`LETTER_W-1:0] word,
    input  wordGamePkg::scanCmd_t               cmd,
    output wordGamePkg::scanResult_t            result
);

    logic [`WORD_LEN-1:0] revealed;
    logic                 turnHit;
    logic                 match;
    logic                 firstStep;

    // ============================================================
    // position compare
    // ============================================================
    assign match     = cmd.step && (word[cmd.position] == cmd.guess);
    assign firstStep = cmd.step && (cmd.position == '0);  // position 0 opens a new turn.

    // ============================================================
    // mask and turn hit
    // ============================================================
    // A position once revealed stays revealed until the next clear, so a
    // repeated guess of a known letter still counts as a hit.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            revealed <= '0;
            turnHit  <= 1'b0;
        end else if (cmd.clear) begin
            revealed <= '0;
            turnHit  <= 1'b0;
        end else if (cmd.step) begin
            if (match) begin
                revealed[cmd.position] <= 1'b1;
            end
            // the hit from earlier turns is dropped on the first step.
            turnHit <= match | (turnHit & ~firstStep);
        end
    end

    assign result.revealed = revealed;
    assign result.turnHit  = turnHit;

endmodule

/* source/gameControl.sv */
// Game control FSM.
// Sequences each turn through the scanner, counts mistakes and decides win or loss.
`timescale 1ns/1ps
`include "wordGame_config.svh"

module gameControl (
    input  logic                     clk,
    input  logic                     nRst,
    input  logic                     start,
    input  logic                     guessStrobe,
    input  logic [`LETTER_W-1:0]     guessLetter,
    input  wordGamePkg::scanResult_t result,
    output wordGamePkg::scanCmd_t    cmd,
    output logic                     loadEnable,
    output wordGamePkg::gameStatus_t status
);
    import wordGamePkg::*;

    gameState_t           state;
    gameState_t           nextState;
    logic                 playing;      // set by start, cleared when the game is over.
    logic [POS_W-1:0]     position;
    logic [`LETTER_W-1:0] heldGuess;
    logic [MIS_W-1:0]     mistakes;
    logic [MIS_W-1:0]     mistakesNext;
    logic                 hitReg;
    logic                 ready;
    logic                 accept;
    logic                 lastPos;
    logic                 judging;
    logic                 wordFull;
    logic                 judgeLost;

    // ============================================================
    // turn decode
    // ============================================================
    assign ready     = (state == IDLE) && playing;
    assign accept    = guessStrobe && ready && !start;  // start wins over a guess.
    assign lastPos   = (position == POS_W'(`WORD_LEN - 1));
    assign judging   = (state == JUDGE);
    assign wordFull  = &result.revealed;

    // the count moves on in the judge cycle itself.
    assign mistakesNext = (judging && !result.turnHit) ? mistakes + 1'b1 : mistakes;
    assign judgeLost    = judging && !wordFull && (mistakesNext == MIS_W'(`MAX_MISTAKES));

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (accept) nextState = SCAN;
            end
            SCAN: begin
                if (lastPos) nextState = JUDGE;
            end
            JUDGE: begin
                if (wordFull) begin
                    nextState = WON;
                end else if (judgeLost) begin
                    nextState = LOST;
                end else begin
                    nextState = IDLE;
                end
            end
            WON, LOST: nextState = state;  // held until the next start.
            default:   nextState = IDLE;
        endcase
        if (start) begin
            nextState = IDLE;
        end
    end

    // ============================================================
    // state and counters
    // ============================================================
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= IDLE;
            playing  <= 1'b0;
            position <= '0;
            mistakes <= '0;
            hitReg   <= 1'b0;
        end else begin
            state <= nextState;
            if (start) begin
                playing  <= 1'b1;
                position <= '0;
                mistakes <= '0;
                hitReg   <= 1'b0;
            end else begin
                if (state == SCAN) begin
                    position <= lastPos ? '0 : position + 1'b1;
                end
                if (judging) begin
                    mistakes <= mistakesNext;
                    hitReg   <= result.turnHit;
                    if (wordFull || judgeLost) begin
                        playing <= 1'b0;
                    end
                end
            end
        end
    end

    // guess is held for the whole scan.
    always_ff @(posedge clk) begin
        if (accept) begin
            heldGuess <= guessLetter;
        end
    end

    // ============================================================
    // outputs
    // ============================================================
    assign cmd.clear    = start;
    assign cmd.step     = (state == SCAN);
    assign cmd.position = position;
    assign cmd.guess    = heldGuess;

    assign loadEnable = !playing;

    assign status.ready    = ready;
    assign status.turnDone = judging;
    assign status.hit      = judging ? result.turnHit : hitReg;
    assign status.mistakes = mistakesNext;
    assign status.won      = (state == WON) || (judging && wordFull);
    assign status.lost     = (state == LOST) || judgeLost;

endmodule

/* source/wordGameTop.sv */
// Word game core top level.
// Joins loader, scanner and control and shows the revealed letters.
`timescale 1ns/1ps
`include "wordGame_config.svh"

module wordGameTop (
    input  logic                                clk,
    input  logic                                nRst,
    input  logic                                loadStrobe,
    input  logic [`LETTER_W-1:0]                loadLetter,
    input  logic                                start,
    input  logic                                guessStrobe,
    input  logic [`LETTER_W-1:0]                guessLetter,
    output wordGamePkg::gameStatus_t            status,
    output logic [`WORD_LEN-1:0][`LETTER_W-1:0] revealedWord
);
    import wordGamePkg::*;

    logic [`WORD_LEN-1:0][`LETTER_W-1:0] word;
    logic                                loadEnable;
    scanCmd_t                            cmd;
    scanResult_t                         result;

    // ============================================================
    // blocks
    // ============================================================
    wordLoader i_loader (
        .clk        (clk),
        .nRst       (nRst),
        .loadStrobe (loadStrobe),
        .loadLetter (loadLetter),
        .loadEnable (loadEnable),
        .word       (word)
    );

    letterScanner i_scanner (
        .clk    (clk),
        .nRst   (nRst),
        .word   (word),
        .cmd    (cmd),
        .result (result)
    );

    gameControl i_control (
        .clk         (clk),
        .nRst        (nRst),
        .start       (start),
        .guessStrobe (guessStrobe),
        .guessLetter (guessLetter),
        .result      (result),
        .cmd         (cmd),
        .loadEnable  (loadEnable),
        .status      (status)
    );

    // hidden letters read as zero.
    always_comb begin
        for (int i = 0; i < `WORD_LEN; i++) begin
            revealedWord[i] = result.revealed[i] ? word[i] : '0;
        end
    end

endmodule

/* verification/tbClock.sv */
// Testbench clock and reset.
// 4 ns clock, reset held low for the first four cycles.
`timescale 1ns/1ps

module tbClock #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic nRst
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        nRst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        nRst <= 1'b1;  // released on a clock edge.
    end

endmodule

/* verification/wordGame_properties.sv */
// Control timing checks.
// Bound into the game FSM, watches the status outputs against the state and the guess strobe.
`timescale 1ns/1ps
`include "wordGame_config.svh"

module wordGame_properties (
    input logic                     clk,
    input logic                     nRst,
    input logic                     start,
    input logic                     guessStrobe,
    input wordGamePkg::gameState_t  state,
    input wordGamePkg::gameStatus_t status
);
    import wordGamePkg::*;

    // ============================================================
    // turn judge pulse
    // ============================================================
    turnDonePulse: assert property (
        @(posedge clk) disable iff (!nRst)
        status.turnDone |=> !status.turnDone
    ) else $error("turnDone stayed high for more than one cycle");

    // an accepted guess drops ready and is judged WORD_LEN+1 cycles after the strobe.
    scanTiming: assert property (
        @(posedge clk) disable iff (!nRst)
        (status.ready && guessStrobe && !start)
            |=> !status.ready ##(`WORD_LEN) status.turnDone
    ) else $error("an accepted guess did not follow the scan and judge timing");

    // ============================================================
    // outcome and busy flags
    // ============================================================
    outcomeExclusive: assert property (
        @(posedge clk) disable iff (!nRst)
        !(status.won && status.lost)
    ) else $error("won and lost are high together");

    // a scan never hands back to a ready wait before it is judged.
    notReadyInScan: assert property (
        @(posedge clk) disable iff (!nRst)
        (state == SCAN && !start) |=> !status.ready
    ) else $error("ready came back while a scan was still running");

endmodule

/* verification/wordGameTb.sv */
// Word game testbench.
// Plays seeded random games against a reference model and checks status and reveals.
`timescale 1ns/1ps
`include "wordGame_config.svh"

module wordGameTb;
    import wordGamePkg::*;

    localparam int NUM_RANDOM = 8;
    localparam int NUM_GAMES  = NUM_RANDOM + 4;
    localparam int TURN_LIMIT = `WORD_LEN + 8;  // cycles allowed for one turn.
    localparam int RUN_LIMIT  = NUM_GAMES * (`WORD_LEN + `MAX_MISTAKES + 26) * (`WORD_LEN + 4);

    logic                                clk;
    logic                                nRst;
    logic                                loadStrobe;
    logic [`LETTER_W-1:0]                loadLetter;
    logic                                start;
    logic                                guessStrobe;
    logic [`LETTER_W-1:0]                guessLetter;
    gameStatus_t                         status;
    logic [`WORD_LEN-1:0][`LETTER_W-1:0] revealedWord;

    // reference model of one game.
    logic [`LETTER_W-1:0] modelWord [`WORD_LEN];
    logic [`WORD_LEN-1:0] modelMask;
    int                   modelMistakes;
    bit                   modelWon;
    bit                   modelLost;

    int checkCount;
    int errorCount;
    int testCount;
    int testErrors;

    tbClock i_clock (
        .clk  (clk),
        .nRst (nRst)
    );

    wordGameTop i_dut (
        .clk          (clk),
        .nRst         (nRst),
        .loadStrobe   (loadStrobe),
        .loadLetter   (loadLetter),
        .start        (start),
        .guessStrobe  (guessStrobe),
        .guessLetter  (guessLetter),
        .status       (status),
        .revealedWord (revealedWord)
    );

    bind gameControl wordGame_properties i_props (
        .clk         (clk),
        .nRst        (nRst),
        .start       (start),
        .guessStrobe (guessStrobe),
        .state       (state),
        .status      (status)
    );

    // ============================================================
    // checking and model
    // ============================================================
    task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch at %0t ns: %s (got %0h, expected %0h)",
                     $time, what, actual, expected);
        end
    endtask

    task automatic finishTest(input string name);
        testCount++;
        $display("test %0d %-24s %s", testCount, name,
                 (errorCount == testErrors) ? "ok" : "failed");
        testErrors = errorCount;
    endtask

    function automatic bit inWord(input logic [`LETTER_W-1:0] letter);
        for (int i = 0; i < `WORD_LEN; i++) begin
            if (modelWord[i] == letter) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [`LETTER_W-1:0] randomLetter(input int alphabet);
        return `LETTER_W'(65 + $urandom % alphabet);  // capitals from A upward.
    endfunction

    function automatic logic [`LETTER_W-1:0] absentLetter();
        int                   first;
        logic [`LETTER_W-1:0] cand;
        first = $urandom % 26;
        for (int k = 0; k < 26; k++) begin
            cand = `LETTER_W'(65 + (first + k) % 26);
            if (!inWord(cand)) return cand;
        end
        return '0;
    endfunction

    // a match reveals every equal position, a miss costs one mistake.
    task automatic applyGuess(input logic [`LETTER_W-1:0] letter, output bit hit);
        hit = 1'b0;
        for (int i = 0; i < `WORD_LEN; i++) begin
            if (modelWord[i] == letter) begin
                modelMask[i] = 1'b1;
                hit          = 1'b1;
            end
        end
        if (!hit) modelMistakes++;
        modelWon  = &modelMask;
        modelLost = !modelWon && (modelMistakes == `MAX_MISTAKES);
    endtask

    task automatic checkStatus(input string what);
        logic [`LETTER_W-1:0] expLetter;
        checkValue(status.mistakes, modelMistakes, {what, ": mistakes"});
        checkValue(status.won, modelWon, {what, ": won"});
        checkValue(status.lost, modelLost, {what, ": lost"});
        for (int i = 0; i < `WORD_LEN; i++) begin
            expLetter = modelMask[i] ? modelWord[i] : '0;
            checkValue(revealedWord[i], expLetter, {what, ": revealed letter"});
        end
    endtask

    // ============================================================
    // stimulus
    // ============================================================
    task automatic shiftLetter(input logic [`LETTER_W-1:0] letter);
        @(posedge clk);
        loadStrobe <= 1'b1;
        loadLetter <= letter;
        @(posedge clk);
        loadStrobe <= 1'b0;
    endtask

    task automatic makeWord(input int alphabet);
        for (int i = 0; i < `WORD_LEN; i++) begin
            modelWord[i] = randomLetter(alphabet);
        end
    endtask

    task automatic loadWord();
        for (int i = 0; i < `WORD_LEN; i++) begin
            shiftLetter(modelWord[i]);  // first letter ends at position 0.
        end
    endtask

    task automatic startGame();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        modelMask     = '0;
        modelMistakes = 0;
        modelWon      = 1'b0;
        modelLost     = 1'b0;
        @(negedge clk);
        checkValue(status.ready, 1'b1, "ready after start");
        checkValue(status.turnDone, 1'b0, "turnDone after start");
        checkStatus("after start");
    endtask

    // busy strobes land two cycles into the scan and must be dropped.
    task automatic playTurn(input logic [`LETTER_W-1:0] letter, input bit busyGuess,
                            input bit busyLoad);
        int cycles;
        bit done;
        bit hit;
        cycles = 0;
        done   = 1'b0;
        @(posedge clk);
        guessStrobe <= 1'b1;
        guessLetter <= letter;
        while (!done && cycles < TURN_LIMIT) begin
            @(posedge clk);
            cycles++;
            if (cycles == 1) guessStrobe <= 1'b0;
            if (cycles == 2) begin
                guessStrobe <= busyGuess;
                guessLetter <= randomLetter(26);
                loadStrobe  <= busyLoad;
                loadLetter  <= randomLetter(26);
            end
            if (cycles == 3) begin
                guessStrobe <= 1'b0;
                loadStrobe  <= 1'b0;
            end
            @(negedge clk);
            if (cycles == 1) checkValue(status.ready, 1'b0, "ready during scan");
            done = status.turnDone;
        end
        if (!done) begin
            errorCount++;
            $display("turnDone did not arrive within %0d cycles of a guess, at %0t ns",
                     TURN_LIMIT, $time);
        end else begin
            applyGuess(letter, hit);
            checkValue(cycles, `WORD_LEN + 1, "turnDone latency");
            checkValue(status.hit, hit, "hit");
            checkStatus("turn result");
        end
        @(posedge clk);
        guessStrobe <= 1'b0;
        loadStrobe  <= 1'b0;
        @(negedge clk);
        checkValue(status.turnDone, 1'b0, "turnDone pulse length");
        checkValue(status.ready, !(modelWon || modelLost), "ready after turn");
        if (done) checkValue(status.hit, hit, "hit held after turn");
        checkStatus("after turn");
    endtask

    task automatic holdAfterEnd(input int count);
        for (int n = 0; n < count; n++) begin
            @(posedge clk);
            guessStrobe <= 1'($urandom % 2);
            guessLetter <= randomLetter(26);
            @(negedge clk);
            checkValue(status.turnDone, 1'b0, "turnDone after game end");
            checkValue(status.ready, 1'b0, "ready after game end");
            checkStatus("held after game end");
        end
        @(posedge clk);
        guessStrobe <= 1'b0;
    endtask

    // each letter is tried at most once, so a game always ends.
    task automatic playRandomGame(input int alphabet);
        bit                   tried [26];
        int                   idx;
        int                   turns;
        logic [`LETTER_W-1:0] letter;
        for (int k = 0; k < 26; k++) tried[k] = 1'b0;
        turns = 0;
        makeWord(alphabet);
        loadWord();
        startGame();
        while (!modelWon && !modelLost && turns < 26) begin
            if ($urandom % 2) begin
                idx = int'(modelWord[$urandom % `WORD_LEN]) - 65;
            end else begin
                idx = $urandom % 26;
            end
            while (tried[idx]) idx = (idx + 1) % 26;
            tried[idx] = 1'b1;
            letter     = `LETTER_W'(65 + idx);
            playTurn(letter, 1'($urandom % 2), 1'($urandom % 2));
            turns++;
        end
    endtask

    // ============================================================
    // test sequence
    // ============================================================
    initial begin
        int mid;
        loadStrobe  = 1'b0;
        loadLetter  = '0;
        start       = 1'b0;
        guessStrobe = 1'b0;
        guessLetter = '0;
        checkCount  = 0;
        errorCount  = 0;
        testCount   = 0;
        testErrors  = 0;
        modelMask     = '0;
        modelMistakes = 0;
        modelWon      = 1'b0;
        modelLost     = 1'b0;
        for (int i = 0; i < `WORD_LEN; i++) modelWord[i] = '0;
        void'($urandom(32'ha595_c853));

        @(posedge nRst);
        @(negedge clk);
        checkValue(status.ready, 1'b0, "ready after reset");
        checkValue(status.turnDone, 1'b0, "turnDone after reset");
        checkStatus("after reset");
        // no game yet, so this guess goes nowhere.
        @(posedge clk);
        guessStrobe <= 1'b1;
        guessLetter <= randomLetter(26);
        @(posedge clk);
        guessStrobe <= 1'b0;
        repeat (`WORD_LEN + 3) begin
            @(negedge clk);
            checkValue(status.turnDone, 1'b0, "turnDone for a guess before start");
        end
        finishTest("reset state");

        makeWord(26);
        loadWord();
        startGame();
        for (int i = 0; i < `WORD_LEN; i++) shiftLetter(randomLetter(26));
        for (int i = 0; i < `WORD_LEN; i++) begin
            if (!modelMask[i]) playTurn(modelWord[i], 1'b0, 1'b1);
        end
        checkValue(status.won, 1'b1, "won after guessing every letter");
        for (int i = 0; i < `WORD_LEN; i++) begin
            checkValue(revealedWord[i], modelWord[i], "revealed word after win");
        end
        finishTest("load and win");

        makeWord(26);
        loadWord();
        startGame();
        repeat (`MAX_MISTAKES) playTurn(absentLetter(), 1'b1, 1'b1);
        checkValue(status.lost, 1'b1, "lost at the mistake limit");
        holdAfterEnd(2 * `WORD_LEN);
        finishTest("mistake limit");

        makeWord(3);
        modelWord[`WORD_LEN-1] = modelWord[0];
        mid = `WORD_LEN / 2;
        if (mid != 0 && mid != `WORD_LEN - 1) begin
            modelWord[mid] = `LETTER_W'(65 + (int'(modelWord[0]) - 64) % 3);
        end
        loadWord();
        startGame();
        playTurn(modelWord[0], 1'b1, 1'b0);
        checkValue(revealedWord[`WORD_LEN-1], modelWord[0], "duplicate letter revealed");
        if (!modelWon) begin
            repeat (2) playTurn(modelWord[0], 1'b1, 1'b0);
            checkValue(status.mistakes, 0, "mistake for a repeated letter");
        end
        startGame();  // restart from the middle of a game.
        for (int i = 0; i < `WORD_LEN; i++) begin
            if (!modelMask[i]) playTurn(modelWord[i], 1'b0, 1'b0);
        end
        checkValue(status.won, 1'b1, "won after restart");
        finishTest("repeats and duplicates");

        for (int g = 0; g < NUM_RANDOM; g++) begin
            playRandomGame((g % 2 == 1) ? 26 : 3 + int'($urandom % 4));
            finishTest($sformatf("random game %0d", g));
        end

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog sized from the number of games and their longest turns.
    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("run timed out after %0d clock cycles", RUN_LIMIT);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* build.f */
+incdir+include
source/wordGamePkg.sv
source/wordLoader.sv
source/letterScanner.sv
source/gameControl.sv
source/wordGameTop.sv
verification/tbClock.sv
verification/wordGame_properties.sv
verification/wordGameTb.sv

/* Makefile */
# Verilator build and run for the word game core.

VERILATOR ?= verilator
TOP       ?= wordGameTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= === PASS ===
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_FLAGS ?=

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_FLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx '$(PASS_TEXT)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
